/* logic/dot_pkg.sv */
// lane count, operand and sum widths, lane vector and grouping pattern types
`default_nettype none

package dot_pkg;

    // four lanes, one pattern bit between each adjacent pair
    localparam int lanes     = 4;
    localparam int pattern_w = lanes - 1;

    // each adder level grows the result by one bit
    localparam int byte_w    = 8;
    localparam int product_w = 2 * byte_w;
    localparam int partial_w = product_w + 1;
    localparam int sum_w     = partial_w + 1;

    // signed matrix or vector operand
    typedef logic signed [byte_w-1:0]    byte_t;

    // full-precision lane product
    typedef logic signed [product_w-1:0] product_t;

    // sum of at most two adjacent products
    typedef logic signed [partial_w-1:0] partial_t;

    // sum of up to four products, cannot overflow
    typedef logic signed [sum_w-1:0]     sum_t;

    // bit i set means lanes i and i+1 sit in different groups
    typedef logic [pattern_w-1:0]        pattern_t;

    // lane 0 in the low bits of every vector
    typedef product_t [lanes-1:0]        product_vec_t;
    typedef partial_t [lanes-1:0]        partial_vec_t;
    typedef sum_t     [lanes-1:0]        sum_vec_t;

endpackage

`default_nettype wire

/* logic/lane_multiply.sv */
// first pipeline stage, four signed lane multipliers with registered products
`timescale 1ns/10ps
`default_nettype none

module lane_multiply
    import dot_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire                in_valid,
    input  wire byte_t [lanes-1:0] mat,
    input  wire byte_t [lanes-1:0] vec,
    input  wire pattern_t      pattern,
    output product_vec_t       prod,
    output pattern_t           prod_pattern,
    output logic               prod_valid
);

    product_vec_t prod_next;

    // operands are signed, so each product is sign-extended to 16 bits
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            prod_next[i] = mat[i] * vec[i];
        end
    end

    // products and pattern load only on a valid beat and hold otherwise
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            prod         <= '0;
            prod_pattern <= '0;
            prod_valid   <= 1'b0;
        end else begin
            prod_valid <= in_valid;
            if (in_valid) begin
                prod         <= prod_next;
                prod_pattern <= pattern;
            end
        end
    end

    // the pattern steers both later stages, so it must be known on entry
    pattern_known: assert property (
        @(posedge clk) disable iff (!rst)
        in_valid |-> !$isunknown(pattern)
    ) else begin
        $error("lane_multiply: pattern has unknown bits on a valid beat");
    end

endmodule

`default_nettype wire

/* logic/pair_reduce.sv */
// second pipeline stage, adds lane pairs 0+1 and 2+3 where the pattern joins them
`timescale 1ns/10ps
`default_nettype none

module pair_reduce
    import dot_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire                prod_valid,
    input  wire product_vec_t  prod,
    input  wire pattern_t      prod_pattern,
    output partial_vec_t       part,
    output pattern_t           part_pattern,
    output logic               part_valid
);

    partial_vec_t part_next;

    // pair p covers lanes 2p and 2p+1, split or joined by pattern bit 2p
    always_comb begin
        for (int p = 0; p < lanes / 2; p++) begin
            if (prod_pattern[2*p]) begin
                // separate groups, both products just widen
                part_next[2*p]   = partial_t'(prod[2*p]);
                part_next[2*p+1] = partial_t'(prod[2*p+1]);
            end else begin
                // joined, the pair sum sits in the lower slot
                part_next[2*p]   = partial_t'(prod[2*p]) + partial_t'(prod[2*p+1]);
                part_next[2*p+1] = '0;
            end
        end
    end

    // pattern travels with its data for the merge across the middle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            part         <= '0;
            part_pattern <= '0;
            part_valid   <= 1'b0;
        end else begin
            part_valid <= prod_valid;
            if (prod_valid) begin
                part         <= part_next;
                part_pattern <= prod_pattern;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/group_compact.sv */
// third pipeline stage, merges across the middle boundary and packs group sums into slots
`timescale 1ns/10ps
`default_nettype none

module group_compact
    import dot_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire                part_valid,
    input  wire partial_vec_t  part,
    input  wire pattern_t      part_pattern,
    output sum_vec_t           sum,
    output logic               sum_valid
);

    // pair results widened to full sum width, after the middle merge
    sum_vec_t         widened;
    // bit i set when a group starts at lane i
    logic [lanes-1:0] group_start;
    // slot holding the last group of the lower pair
    int unsigned      lower_last;
    // next free output slot during compaction
    int unsigned      slot;
    sum_vec_t         sum_next;

    // lane 0 always opens a group, any set pattern bit opens the next
    assign group_start = {part_pattern, 1'b1};

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            widened[i] = sum_t'(part[i]);
        end
        // lower pair ends in slot 1 only when lanes 0 and 1 were split
        lower_last = part_pattern[0] ? 1 : 0;
        if (!part_pattern[1]) begin
            // first upper group folds into the last lower group
            widened[lower_last] = widened[lower_last] + widened[2];
        end
    end

    // walk the lanes and copy each group's sum to the next free slot
    always_comb begin
        sum_next = '0;
        slot     = 0;
        for (int i = 0; i < lanes; i++) begin
            if (group_start[i]) begin
                sum_next[slot] = widened[i];
                slot           = slot + 1;
            end
        end
    end

    // result holds the last beat between valid pulses
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sum       <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= part_valid;
            if (part_valid) begin
                sum <= sum_next;
            end
        end
    end

    // group count is one plus the set pattern bits of the beat that loaded
    unused_slots_zero: assert property (
        @(posedge clk) disable iff (!rst)
        sum_valid |->
            ((sum >> (sum_w * (1 + $countones($past(part_pattern))))) == '0)
    ) else begin
        $error("group_compact: nonzero slot above the group count");
    end

endmodule

`default_nettype wire

/* logic/dot_top.sv */
// dot-product unit top level, flat ports around the three pipeline stages
`timescale 1ns/10ps
`default_nettype none

module dot_top
    import dot_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      in_valid,
    input  wire  [lanes*byte_w-1:0]  mat,
    input  wire  [lanes*byte_w-1:0]  vec,
    input  wire  [pattern_w-1:0]     pattern,
    output logic                     out_valid,
    output logic [lanes*sum_w-1:0]   result
);

    // flat operands split into lanes, lane 0 in the low byte
    byte_t [lanes-1:0] mat_lanes;
    byte_t [lanes-1:0] vec_lanes;
    pattern_t          in_pattern;

    // multiply stage to pair stage
    product_vec_t      prod;
    pattern_t          prod_pattern;
    logic              prod_valid;

    // pair stage to compact stage
    partial_vec_t      part;
    pattern_t          part_pattern;
    logic              part_valid;

    // compacted slots
    sum_vec_t          sum;
    logic              sum_valid;

    assign mat_lanes  = mat;
    assign vec_lanes  = vec;
    assign in_pattern = pattern;

    lane_multiply u_lane_multiply (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .mat          (mat_lanes),
        .vec          (vec_lanes),
        .pattern      (in_pattern),
        .prod         (prod),
        .prod_pattern (prod_pattern),
        .prod_valid   (prod_valid)
    );

    pair_reduce u_pair_reduce (
        .clk          (clk),
        .rst          (rst),
        .prod_valid   (prod_valid),
        .prod         (prod),
        .prod_pattern (prod_pattern),
        .part         (part),
        .part_pattern (part_pattern),
        .part_valid   (part_valid)
    );

    group_compact u_group_compact (
        .clk          (clk),
        .rst          (rst),
        .part_valid   (part_valid),
        .part         (part),
        .part_pattern (part_pattern),
        .sum          (sum),
        .sum_valid    (sum_valid)
    );

    // slot 0 lands in the low bits of result
    assign result    = sum;
    assign out_valid = sum_valid;

endmodule

`default_nettype wire

/* verif/dot_tb_cases.svh */
// directed beat table with operands, grouping patterns and expected slot sums
`ifndef DOT_TB_CASES_SVH
`define DOT_TB_CASES_SVH

// columns: mat, vec (lane 0 in the low byte), pattern, expected slots 0 to 3
typedef struct packed {
    logic [31:0] mat;
    logic [31:0] vec;
    pattern_t    pattern;
    sum_t        slot0;
    sum_t        slot1;
    sum_t        slot2;
    sum_t        slot3;
} beat_case_t;

localparam int num_cases = 16;

localparam beat_case_t cases [num_cases] = '{
    // products 5, 12, 21, 32 under all eight patterns
    '{32'h04030201, 32'h08070605, 3'b000, 18'sd70, 18'sd0, 18'sd0, 18'sd0},
    '{32'h04030201, 32'h08070605, 3'b001, 18'sd5, 18'sd65, 18'sd0, 18'sd0},
    '{32'h04030201, 32'h08070605, 3'b010, 18'sd17, 18'sd53, 18'sd0, 18'sd0},
    '{32'h04030201, 32'h08070605, 3'b011, 18'sd5, 18'sd12, 18'sd53, 18'sd0},
    '{32'h04030201, 32'h08070605, 3'b100, 18'sd38, 18'sd32, 18'sd0, 18'sd0},
    '{32'h04030201, 32'h08070605, 3'b101, 18'sd5, 18'sd33, 18'sd32, 18'sd0},
    '{32'h04030201, 32'h08070605, 3'b110, 18'sd17, 18'sd21, 18'sd32, 18'sd0},
    '{32'h04030201, 32'h08070605, 3'b111, 18'sd5, 18'sd12, 18'sd21, 18'sd32},
    // products -5, 12, -21, 32
    '{32'h04fd02ff, 32'h08070605, 3'b000, 18'sd18, 18'sd0, 18'sd0, 18'sd0},
    '{32'h04fd02ff, 32'h08070605, 3'b010, 18'sd7, 18'sd11, 18'sd0, 18'sd0},
    '{32'h04fd02ff, 32'h08070605, 3'b101, -18'sd5, -18'sd9, 18'sd32, 18'sd0},
    // -128 times -128 in every lane
    '{32'h80808080, 32'h80808080, 3'b000, 18'sd65536, 18'sd0, 18'sd0, 18'sd0},
    '{32'h80808080, 32'h80808080, 3'b111, 18'sd16384, 18'sd16384, 18'sd16384, 18'sd16384},
    // -128 times 127 in every lane
    '{32'h80808080, 32'h7f7f7f7f, 3'b000, -18'sd65024, 18'sd0, 18'sd0, 18'sd0},
    '{32'h80808080, 32'h7f7f7f7f, 3'b010, -18'sd32512, -18'sd32512, 18'sd0, 18'sd0},
    '{32'h80808080, 32'h7f7f7f7f, 3'b110, -18'sd32512, -18'sd16256, -18'sd16256, 18'sd0}
};

`endif

/* verif/dot_tb.sv */
// testbench for the dot-product unit with clock, reset, beat driver, reference model and checks
`timescale 1ns/10ps
`default_nettype none

module dot_tb
    import dot_pkg::*;
;

    localparam int unsigned seed        = 32'ha877_dc48;
    localparam int          drain_limit = 50;
    localparam int          num_random  = 300;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [31:0] mat;
    logic [31:0] vec;
    logic [2:0]  pattern;
    logic        out_valid;
    logic [71:0] result;

    // beats in flight with the oldest first
    sum_vec_t expected_q [$];
    string    name_q [$];
    int       due_q [$];

    int          cycle = 0;
    logic [71:0] last_result = '0;

    `include "dot_tb_cases.svh"

    dot_top DUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .mat       (mat),
        .vec       (vec),
        .pattern   (pattern),
        .out_valid (out_valid),
        .result    (result)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic report_failure();
        $display("Test FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [71:0] expected,
                               input logic [71:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            report_failure();
        end
    endtask

    // groups close at every set pattern bit and after lane 3
    function automatic sum_vec_t group_sums(input logic [31:0] m, input logic [31:0] v,
                                            input pattern_t p);
        sum_vec_t         slots;
        logic [lanes-1:0] split;
        int               acc;
        int               idx;
        int               prod;
        slots = '0;
        split = {1'b1, p};
        acc   = 0;
        idx   = 0;
        for (int i = 0; i < lanes; i++) begin
            prod = int'($signed(m[8*i +: 8])) * int'($signed(v[8*i +: 8]));
            acc  = acc + prod;
            if (split[i]) begin
                slots[idx] = sum_t'(acc);
                idx        = idx + 1;
                acc        = 0;
            end
        end
        return slots;
    endfunction

    function automatic sum_vec_t case_slots(input beat_case_t c);
        return {c.slot3, c.slot2, c.slot1, c.slot0};
    endfunction

    // a beat driven after edge k leaves the pipe after edge k+3
    task automatic drive_beat(input logic [31:0] m, input logic [31:0] v, input pattern_t p,
                              input sum_vec_t expected, input string name);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        mat      = m;
        vec      = v;
        pattern  = p;
        expected_q.push_back(expected);
        name_q.push_back(name);
        due_q.push_back(cycle + 3);
    endtask

    // junk operands while idle must not reach the result
    task automatic drive_idle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        mat      = $urandom;
        vec      = $urandom;
        pattern  = pattern_t'($urandom);
    endtask

    task automatic wait_drain(input string phase);
        int waited;
        waited = 0;
        while (expected_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > drain_limit) begin
                $display("timeout: beats of the %s phase never left the pipe", phase);
                report_failure();
            end
        end
    endtask

    // sample away from the rising edge where outputs are stable
    always @(negedge clk) begin
        if (rst) begin
            if (out_valid) begin
                if (expected_q.size() == 0) begin
                    $display("out_valid pulsed at cycle %0d with no beat outstanding", cycle);
                    report_failure();
                end else begin
                    check_value($sformatf("%s arrival cycle", name_q[0]),
                                72'(due_q[0]), 72'(cycle));
                    check_value(name_q[0], expected_q[0], result);
                    last_result = result;
                    void'(expected_q.pop_front());
                    void'(name_q.pop_front());
                    void'(due_q.pop_front());
                end
            end else begin
                check_value("result hold", last_result, result);
                if (due_q.size() != 0 && cycle > due_q[0]) begin
                    $display("beat %s overdue, out_valid missing at cycle %0d",
                             name_q[0], due_q[0]);
                    report_failure();
                end
            end
        end
    end

    initial begin
        logic [31:0] m;
        logic [31:0] v;
        pattern_t    p;
        int          gap;
        void'($urandom(seed));
        clk      = 1'b0;
        rst      = 1'b0;
        in_valid = 1'b0;
        mat      = '0;
        vec      = '0;
        pattern  = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;

        // idle after reset
        repeat (3) drive_idle();
        @(negedge clk);
        check_value("idle out_valid", 72'd0, 72'(out_valid));
        check_value("idle result", 72'd0, result);

        // table beats on consecutive cycles
        for (int i = 0; i < num_cases; i++) begin
            drive_beat(cases[i].mat, cases[i].vec, cases[i].pattern, case_slots(cases[i]),
                       $sformatf("table %0d back to back", i));
        end
        drive_idle();
        wait_drain("back to back");

        // same table with idle gaps of one to three cycles
        for (int i = 0; i < num_cases; i++) begin
            drive_beat(cases[i].mat, cases[i].vec, cases[i].pattern, case_slots(cases[i]),
                       $sformatf("table %0d with gaps", i));
            gap = 1 + int'($urandom % 3);
            for (int g = 0; g < gap; g++) begin
                drive_idle();
            end
        end
        wait_drain("gapped");

        // random operands and patterns against the reference model
        for (int n = 0; n < num_random; n++) begin
            if ($urandom % 4 != 0) begin
                m = $urandom;
                v = $urandom;
                p = pattern_t'($urandom);
                drive_beat(m, v, p, group_sums(m, v, p), $sformatf("random %0d", n));
            end else begin
                drive_idle();
            end
        end
        drive_idle();
        wait_drain("random");
        repeat (4) drive_idle();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verif
logic/dot_pkg.sv
logic/lane_multiply.sv
logic/pair_reduce.sv
logic/group_compact.sv
logic/dot_top.sv
verif/dot_tb.sv

/* Makefile */
TOP := dot_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)

# the log decides pass or fail
run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
